//--- hdl/daq_pkg.sv
package daq_pkg;

    // ------------------------------------------------------------------------
    // widths
    // ------------------------------------------------------------------------
    localparam int DATA_W     = 16;                // bus and sample width
    localparam int ADDR_W     = 9;
    localparam int NUM_CH     = 4;
    localparam int CH_W       = $clog2(NUM_CH);
    localparam int PERIOD_W   = 32;
    localparam int FIFO_DEPTH = 16;                // small so full shows up in sim

    localparam logic [DATA_W-1:0] VERSION = 16'h1000;

    // ------------------------------------------------------------------------
    // register map, byte addresses on the MCU bus
    // ------------------------------------------------------------------------
    localparam logic [ADDR_W-1:0] ADDR_VERSION  = 9'h000;
    localparam logic [ADDR_W-1:0] ADDR_INTERVAL = 9'h002;
    localparam logic [ADDR_W-1:0] ADDR_PERIOD_L = 9'h00A;
    localparam logic [ADDR_W-1:0] ADDR_PERIOD_H = 9'h00C;
    localparam logic [ADDR_W-1:0] ADDR_ENABLE   = 9'h00E;
    localparam logic [ADDR_W-1:0] ADDR_STATUS   = 9'h014;
    localparam logic [ADDR_W-1:0] ADDR_CH_BASE  = 9'h016;  // channel k at base + 2k
    localparam logic [ADDR_W-1:0] ADDR_DATAFULL = 9'h036;

    // ------------------------------------------------------------------------
    // ADC timing, in AD_CLK_40M cycles
    // ------------------------------------------------------------------------
    localparam int CONVST_LOW_CYCLES = 2;
    localparam int RD_LOW_CYCLES     = 3;
    localparam int ADC_RESET_CYCLES  = 4;

    localparam int unsigned PHASE_TIMEOUT = 40_000_000;  // one second at 40 MHz

    typedef enum logic [2:0] {
        IDLE,
        CONVST,
        WAIT_BUSY_HI,
        WAIT_BUSY_LO,
        RD_LOW,
        RD_HIGH,
        NEXT_CH
    } adc_state_e;

endpackage

//--- hdl/mcu_regs.sv
`timescale 1ns/1ps

module mcu_regs (
    input  logic                          AD_CLK_40M,
    input  logic                          arst_n_i,
    input  logic                          mcu_cs_n_i,
    input  logic                          mcu_we_n_i,
    input  logic                          mcu_rd_n_i,
    input  logic [daq_pkg::ADDR_W-1:0]    mcu_addr_i,
    input  logic [daq_pkg::DATA_W-1:0]    mcu_data_i,
    output logic [daq_pkg::DATA_W-1:0]    mcu_data_o,
    output logic                          mcu_data_oe_o,
    input  logic [daq_pkg::PERIOD_W-1:0]  period_i,
    input  logic [daq_pkg::DATA_W-1:0]    fifo_head_i [daq_pkg::NUM_CH],
    input  logic [daq_pkg::NUM_CH-1:0]    fifo_empty_i,
    input  logic [daq_pkg::NUM_CH-1:0]    fifo_full_i,
    output logic                          enable_o,
    output logic                          enable_rise_o,
    output logic [daq_pkg::DATA_W-1:0]    interval_o,
    output logic [daq_pkg::NUM_CH-1:0]    pop_o
);

    logic                       enable_d;
    logic                       rd_n_d;
    logic                       cs_n_d;
    logic [daq_pkg::ADDR_W-1:0] addr_d;
    logic                       rd_rise;
    logic                       lost_phase;

    // ------------------------------------------------------------------------
    // write side
    // ------------------------------------------------------------------------
    always_ff @(posedge AD_CLK_40M or negedge arst_n_i) begin
        if (!arst_n_i) begin
            interval_o    <= '0;
            enable_o      <= 1'b0;
            enable_d      <= 1'b0;
            enable_rise_o <= 1'b0;
        end else begin
            if (!mcu_cs_n_i && !mcu_we_n_i) begin
                case (mcu_addr_i)
                    daq_pkg::ADDR_INTERVAL: interval_o <= mcu_data_i;
                    daq_pkg::ADDR_ENABLE:   enable_o   <= mcu_data_i[0];
                    default: ;
                endcase
            end
            enable_d      <= enable_o;
            enable_rise_o <= enable_o && !enable_d;   // clears FIFOs, resets ADC
        end
    end

    // bus state of the cycle before, so cs_n may rise together with rd_n
    always_ff @(posedge AD_CLK_40M or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rd_n_d <= 1'b1;
            cs_n_d <= 1'b1;
            addr_d <= '0;
        end else begin
            rd_n_d <= mcu_rd_n_i;
            cs_n_d <= mcu_cs_n_i;
            addr_d <= mcu_addr_i;
        end
    end

    assign rd_rise = mcu_rd_n_i && !rd_n_d && !cs_n_d;

    always_comb begin
        for (int k = 0; k < daq_pkg::NUM_CH; k++) begin
            pop_o[k] = rd_rise && (addr_d == daq_pkg::ADDR_W'(daq_pkg::ADDR_CH_BASE + 2 * k));
        end
    end

    // ------------------------------------------------------------------------
    // read multiplexer
    // ------------------------------------------------------------------------
    assign lost_phase    = (period_i == '0);
    assign mcu_data_oe_o = !mcu_cs_n_i && !mcu_rd_n_i;

    always_comb begin
        mcu_data_o = '0;                              // unmapped reads as 0
        case (mcu_addr_i)
            daq_pkg::ADDR_VERSION:  mcu_data_o = daq_pkg::VERSION;
            daq_pkg::ADDR_INTERVAL: mcu_data_o = interval_o;
            daq_pkg::ADDR_PERIOD_L: mcu_data_o = period_i[15:0];
            daq_pkg::ADDR_PERIOD_H: mcu_data_o = period_i[31:16];
            daq_pkg::ADDR_ENABLE:   mcu_data_o = {15'b0, enable_o};
            daq_pkg::ADDR_STATUS:   mcu_data_o = {12'b0, ~fifo_empty_i};
            daq_pkg::ADDR_DATAFULL: mcu_data_o = {14'b0, lost_phase, &fifo_full_i};
            default: ;
        endcase
        for (int k = 0; k < daq_pkg::NUM_CH; k++) begin
            if (mcu_addr_i == daq_pkg::ADDR_W'(daq_pkg::ADDR_CH_BASE + 2 * k)) begin
                mcu_data_o = fifo_empty_i[k] ? '0 : fifo_head_i[k];
            end
        end
    end

    // one read strobe may only ever drain a single channel
    assert property (@(posedge AD_CLK_40M) disable iff (!arst_n_i) $onehot0(pop_o));

endmodule

//--- hdl/phase_meter.sv
`timescale 1ns/1ps

module phase_meter #(
    parameter int unsigned timeout = daq_pkg::PHASE_TIMEOUT
) (
    input  logic                          AD_CLK_40M,
    input  logic                          arst_n_i,
    input  logic                          phase_i,
    output logic [daq_pkg::PERIOD_W-1:0]  period_o
);

    logic [2:0]                   phase_sync;     // two sync flops plus edge tap
    logic                         phase_rise;
    logic                         seen_q;         // an edge has started the count
    logic [daq_pkg::PERIOD_W-1:0] cnt_q;

    always_ff @(posedge AD_CLK_40M or negedge arst_n_i) begin
        if (!arst_n_i) begin
            phase_sync <= '0;
        end else begin
            phase_sync <= {phase_sync[1:0], phase_i};
        end
    end

    assign phase_rise = phase_sync[1] && !phase_sync[2];

    always_ff @(posedge AD_CLK_40M or negedge arst_n_i) begin
        if (!arst_n_i) begin
            seen_q   <= 1'b0;
            cnt_q    <= '0;
            period_o <= '0;
        end else if (phase_rise) begin
            if (seen_q) begin
                period_o <= cnt_q + 1'b1;             // cycles since last edge
            end
            seen_q <= 1'b1;
            cnt_q  <= '0;
        end else if (cnt_q == daq_pkg::PERIOD_W'(timeout - 1)) begin
            // phase input has stopped, next edge restarts the count
            period_o <= '0;
            seen_q   <= 1'b0;
        end else begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

endmodule

//--- hdl/sample_trigger.sv
`timescale 1ns/1ps

module sample_trigger (
    input  logic                        AD_CLK_40M,
    input  logic                        arst_n_i,
    input  logic                        enable_i,
    input  logic [daq_pkg::DATA_W-1:0]  interval_i,
    output logic                        start_o
);

    logic [daq_pkg::DATA_W-1:0] reload;
    logic [daq_pkg::DATA_W-1:0] cnt_q;

    // intervals of 0 and 1 run as 2
    assign reload = (interval_i < 2) ? daq_pkg::DATA_W'(1) : interval_i - 1'b1;

    always_ff @(posedge AD_CLK_40M or negedge arst_n_i) begin
        if (!arst_n_i) begin
            cnt_q <= '0;
        end else if (!enable_i) begin
            cnt_q <= reload;                          // hold at reload
        end else if (cnt_q == '0) begin
            cnt_q <= reload;
        end else begin
            cnt_q <= cnt_q - 1'b1;
        end
    end

    assign start_o = enable_i && (cnt_q == '0);

    // no start in the first enabled cycle, the count sat at reload
    assert property (@(posedge AD_CLK_40M) disable iff (!arst_n_i)
        start_o |-> enable_i && $past(enable_i));

endmodule

//--- hdl/ad7606_ctrl.sv
`timescale 1ns/1ps

module ad7606_ctrl (
    input  logic                        AD_CLK_40M,
    input  logic                        arst_n_i,
    input  logic                        start_i,
    input  logic                        reset_req_i,
    input  logic [daq_pkg::DATA_W-1:0]  adc_db_i,
    input  logic                        adc_busy_i,
    output logic                        adc_convst_o,
    output logic                        adc_cs_n_o,
    output logic                        adc_rd_n_o,
    output logic                        adc_reset_o,
    output logic [daq_pkg::DATA_W-1:0]  sample_o,
    output logic [daq_pkg::CH_W-1:0]    sample_ch_o,
    output logic                        sample_valid_o
);

    daq_pkg::adc_state_e      state_q;
    logic [2:0]               cnt_q;
    logic [2:0]               rst_cnt_q;
    logic [daq_pkg::CH_W-1:0] ch_q;
    logic                     rd_done;

    assign rd_done = (state_q == daq_pkg::RD_LOW) && (cnt_q == 3'(daq_pkg::RD_LOW_CYCLES - 1));

    // ------------------------------------------------------------------------
    // conversion and readout sequence
    // ------------------------------------------------------------------------
    always_ff @(posedge AD_CLK_40M or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q        <= daq_pkg::IDLE;
            cnt_q          <= '0;
            rst_cnt_q      <= '0;
            ch_q           <= '0;
            sample_ch_o    <= '0;
            sample_valid_o <= 1'b0;
        end else begin
            sample_valid_o <= 1'b0;
            if (rst_cnt_q != '0) begin
                rst_cnt_q <= rst_cnt_q - 1'b1;
            end
            if (reset_req_i) begin
                state_q   <= daq_pkg::IDLE;
                rst_cnt_q <= 3'(daq_pkg::ADC_RESET_CYCLES);
            end else begin
                case (state_q)
                    daq_pkg::IDLE: begin
                        if (start_i && rst_cnt_q == '0) begin   // no start during ADC reset
                            state_q <= daq_pkg::CONVST;
                            cnt_q   <= '0;
                        end
                    end
                    daq_pkg::CONVST: begin
                        if (cnt_q == 3'(daq_pkg::CONVST_LOW_CYCLES - 1)) begin
                            state_q <= daq_pkg::WAIT_BUSY_HI;
                        end else begin
                            cnt_q <= cnt_q + 1'b1;
                        end
                    end
                    daq_pkg::WAIT_BUSY_HI: begin
                        if (adc_busy_i) state_q <= daq_pkg::WAIT_BUSY_LO;
                    end
                    daq_pkg::WAIT_BUSY_LO: begin
                        if (!adc_busy_i) begin            // conversion done
                            state_q <= daq_pkg::RD_LOW;
                            cnt_q   <= '0;
                            ch_q    <= '0;
                        end
                    end
                    daq_pkg::RD_LOW: begin
                        if (rd_done) begin
                            state_q        <= daq_pkg::RD_HIGH;
                            sample_ch_o    <= ch_q;
                            sample_valid_o <= 1'b1;
                        end else begin
                            cnt_q <= cnt_q + 1'b1;
                        end
                    end
                    daq_pkg::RD_HIGH: state_q <= daq_pkg::NEXT_CH;
                    daq_pkg::NEXT_CH: begin
                        if (ch_q == daq_pkg::CH_W'(daq_pkg::NUM_CH - 1)) begin
                            state_q <= daq_pkg::IDLE;
                        end else begin
                            state_q <= daq_pkg::RD_LOW;
                            ch_q    <= ch_q + 1'b1;
                            cnt_q   <= '0;
                        end
                    end
                    default: state_q <= daq_pkg::IDLE;
                endcase
            end
        end
    end

    // data taken as rd_n goes high
    always_ff @(posedge AD_CLK_40M) begin
        if (rd_done && !reset_req_i) sample_o <= adc_db_i;
    end

    assign adc_convst_o = (state_q != daq_pkg::CONVST);
    assign adc_rd_n_o   = (state_q != daq_pkg::RD_LOW);
    assign adc_cs_n_o   = !(state_q inside {daq_pkg::RD_LOW, daq_pkg::RD_HIGH, daq_pkg::NEXT_CH});
    assign adc_reset_o  = (rst_cnt_q != '0);

    // reads only with the chip selected and the conversion over
    assert property (@(posedge AD_CLK_40M) disable iff (!arst_n_i)
        !adc_rd_n_o |-> !adc_cs_n_o && !adc_busy_i);

endmodule

//--- hdl/sample_fifo.sv
`timescale 1ns/1ps

module sample_fifo #(
    parameter int depth = daq_pkg::FIFO_DEPTH
) (
    input  logic                        AD_CLK_40M,
    input  logic                        arst_n_i,
    input  logic                        clear_i,
    input  logic                        wr_i,
    input  logic [daq_pkg::DATA_W-1:0]  data_i,
    input  logic                        rd_i,
    output logic [daq_pkg::DATA_W-1:0]  head_o,
    output logic                        empty_o,
    output logic                        full_o
);

    localparam int AW = $clog2(depth);

    logic [daq_pkg::DATA_W-1:0] mem [depth];
    logic [AW-1:0]              wr_ptr_q;
    logic [AW-1:0]              rd_ptr_q;
    logic [AW:0]                count_q;
    logic                       wr_ok;
    logic                       rd_ok;

    assign wr_ok = wr_i && !full_o;                   // full drops new data
    assign rd_ok = rd_i && !empty_o;

    always_ff @(posedge AD_CLK_40M or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else if (clear_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (wr_ok) wr_ptr_q <= (wr_ptr_q == AW'(depth - 1)) ? '0 : wr_ptr_q + 1'b1;
            if (rd_ok) rd_ptr_q <= (rd_ptr_q == AW'(depth - 1)) ? '0 : rd_ptr_q + 1'b1;
            count_q <= count_q + wr_ok - rd_ok;
        end
    end

    always_ff @(posedge AD_CLK_40M) begin
        if (wr_ok && !clear_i) mem[wr_ptr_q] <= data_i;
    end

    assign head_o  = mem[rd_ptr_q];                   // first word falls through
    assign empty_o = (count_q == '0);
    assign full_o  = (count_q == (AW+1)'(depth));

    assert property (@(posedge AD_CLK_40M) disable iff (!arst_n_i) count_q <= depth);

endmodule

//--- hdl/daq_top.sv
`timescale 1ns/1ps

module daq_top #(
    parameter int          fifo_depth    = daq_pkg::FIFO_DEPTH,
    parameter int unsigned phase_timeout = daq_pkg::PHASE_TIMEOUT
) (
    input  logic                        AD_CLK_40M,
    input  logic                        arst_n_i,
    input  logic                        mcu_cs_n_i,
    input  logic                        mcu_we_n_i,
    input  logic                        mcu_rd_n_i,
    input  logic [daq_pkg::ADDR_W-1:0]  mcu_addr_i,
    input  logic [daq_pkg::DATA_W-1:0]  mcu_data_i,
    output logic [daq_pkg::DATA_W-1:0]  mcu_data_o,
    output logic                        mcu_data_oe_o,
    input  logic [daq_pkg::DATA_W-1:0]  adc_db_i,
    input  logic                        adc_busy_i,
    output logic                        adc_convst_o,
    output logic                        adc_cs_n_o,
    output logic                        adc_rd_n_o,
    output logic                        adc_reset_o,
    input  logic                        phase_i
);

    logic                         enable;
    logic                         enable_rise;
    logic [daq_pkg::DATA_W-1:0]   interval;
    logic                         start;
    logic [daq_pkg::PERIOD_W-1:0] period;
    logic [daq_pkg::DATA_W-1:0]   sample;
    logic [daq_pkg::CH_W-1:0]     sample_ch;
    logic                         sample_valid;
    logic [daq_pkg::DATA_W-1:0]   fifo_head [daq_pkg::NUM_CH];
    logic [daq_pkg::NUM_CH-1:0]   fifo_empty;
    logic [daq_pkg::NUM_CH-1:0]   fifo_full;
    logic [daq_pkg::NUM_CH-1:0]   pop;

    mcu_regs u_regs (
        .AD_CLK_40M, .arst_n_i,
        .mcu_cs_n_i, .mcu_we_n_i, .mcu_rd_n_i, .mcu_addr_i, .mcu_data_i,
        .mcu_data_o, .mcu_data_oe_o,
        .period_i      (period),
        .fifo_head_i   (fifo_head),
        .fifo_empty_i  (fifo_empty),
        .fifo_full_i   (fifo_full),
        .enable_o      (enable),
        .enable_rise_o (enable_rise),
        .interval_o    (interval),
        .pop_o         (pop)
    );

    sample_trigger u_trigger (
        .AD_CLK_40M, .arst_n_i,
        .enable_i   (enable),
        .interval_i (interval),
        .start_o    (start)
    );

    ad7606_ctrl u_adc (
        .AD_CLK_40M, .arst_n_i,
        .start_i        (start),
        .reset_req_i    (enable_rise),
        .adc_db_i, .adc_busy_i,
        .adc_convst_o, .adc_cs_n_o, .adc_rd_n_o, .adc_reset_o,
        .sample_o       (sample),
        .sample_ch_o    (sample_ch),
        .sample_valid_o (sample_valid)
    );

    phase_meter #(.timeout(phase_timeout)) u_phase (
        .AD_CLK_40M, .arst_n_i, .phase_i,
        .period_o (period)
    );

    // one FIFO per ADC channel
    for (genvar k = 0; k < daq_pkg::NUM_CH; k++) begin : g_ch
        sample_fifo #(.depth(fifo_depth)) u_fifo (
            .AD_CLK_40M, .arst_n_i,
            .clear_i (enable_rise),
            .wr_i    (sample_valid && (sample_ch == daq_pkg::CH_W'(k))),
            .data_i  (sample),
            .rd_i    (pop[k]),
            .head_o  (fifo_head[k]),
            .empty_o (fifo_empty[k]),
            .full_o  (fifo_full[k])
        );
    end

endmodule

//--- test/adc_model.sv
`timescale 1ns/1ps

module adc_model (
    input  logic        AD_CLK_40M,
    input  logic        arst_n_i,
    input  logic        convst_i,
    input  logic        cs_n_i,
    input  logic        rd_n_i,
    input  logic        reset_i,
    output logic        busy_o,
    output logic [15:0] db_o
);

    localparam int BUSY_CYCLES = 20;

    logic        convst_d;
    logic        rd_n_d;
    int          busy_cnt;
    logic [11:0] conv_cnt;                            // conversions since ADC reset
    logic [11:0] cur_conv;                            // conversion being read out
    logic [1:0]  ch;

    always_ff @(posedge AD_CLK_40M or negedge arst_n_i) begin
        if (!arst_n_i) begin
            convst_d <= 1'b1;
            rd_n_d   <= 1'b1;
            busy_cnt <= 0;
            conv_cnt <= '0;
            cur_conv <= '0;
            ch       <= '0;
        end else begin
            convst_d <= convst_i;
            rd_n_d   <= rd_n_i;
            if (reset_i) begin
                busy_cnt <= 0;
                conv_cnt <= '0;
                ch       <= '0;
            end else if (convst_i && !convst_d) begin
                cur_conv <= conv_cnt;                 // conversion starts on convst rise
                conv_cnt <= conv_cnt + 1'b1;
                busy_cnt <= BUSY_CYCLES;
                ch       <= '0;
            end else begin
                if (busy_cnt != 0) busy_cnt <= busy_cnt - 1;
                if (rd_n_i && !rd_n_d && !cs_n_i) ch <= ch + 1'b1;
            end
        end
    end

    assign busy_o = (busy_cnt != 0);
    assign db_o   = {2'b00, ch, cur_conv};            // channel in the top nibble

endmodule

//--- test/tb_daq_top.sv
`timescale 1ns/1ps

module tb_daq_top;

    localparam int          FIFO_DEPTH_TB    = 16;
    localparam int unsigned PHASE_TIMEOUT_TB = 2000;
    localparam int          POLL_LIMIT       = 4000;  // bus polls before giving up

    logic                       AD_CLK_40M;
    logic                       arst_n;
    logic                       mcu_cs_n;
    logic                       mcu_we_n;
    logic                       mcu_rd_n;
    logic [daq_pkg::ADDR_W-1:0] mcu_addr;
    logic [15:0]                mcu_wdata;
    logic [15:0]                mcu_rdata;
    logic                       mcu_oe;
    logic [15:0]                adc_db;
    logic                       adc_busy;
    logic                       adc_convst;
    logic                       adc_cs_n;
    logic                       adc_rd_n;
    logic                       adc_reset;
    logic                       phase;

    daq_top #(
        .fifo_depth    (FIFO_DEPTH_TB),
        .phase_timeout (PHASE_TIMEOUT_TB)
    ) u_dut (
        .AD_CLK_40M    (AD_CLK_40M),
        .arst_n_i      (arst_n),
        .mcu_cs_n_i    (mcu_cs_n),
        .mcu_we_n_i    (mcu_we_n),
        .mcu_rd_n_i    (mcu_rd_n),
        .mcu_addr_i    (mcu_addr),
        .mcu_data_i    (mcu_wdata),
        .mcu_data_o    (mcu_rdata),
        .mcu_data_oe_o (mcu_oe),
        .adc_db_i      (adc_db),
        .adc_busy_i    (adc_busy),
        .adc_convst_o  (adc_convst),
        .adc_cs_n_o    (adc_cs_n),
        .adc_rd_n_o    (adc_rd_n),
        .adc_reset_o   (adc_reset),
        .phase_i       (phase)
    );

    adc_model u_adc_model (
        .AD_CLK_40M (AD_CLK_40M),
        .arst_n_i   (arst_n),
        .convst_i   (adc_convst),
        .cs_n_i     (adc_cs_n),
        .rd_n_i     (adc_rd_n),
        .reset_i    (adc_reset),
        .busy_o     (adc_busy),
        .db_o       (adc_db)
    );

    initial begin
        AD_CLK_40M = 1'b0;
        forever #5 AD_CLK_40M = ~AD_CLK_40M;          // 100 MHz in sim
    end

    // ------------------------------------------------------------------------
    // reference model and helpers
    // ------------------------------------------------------------------------
    function automatic logic [15:0] expected_sample(input int k, input int n);
        return 16'(k * 4096 + (n % 4096));
    endfunction

    function automatic logic [daq_pkg::ADDR_W-1:0] ch_addr(input int k);
        return daq_pkg::ADDR_W'(daq_pkg::ADDR_CH_BASE + 2 * k);
    endfunction

    task automatic stop_run(input string reason);
        $display("%s", reason);
        $display("*** FAILED ***");
        $fatal(1, "test stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("Mismatch in %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
            $display("*** FAILED ***");
            $fatal(1, "test stopped");
        end
    endtask

    task automatic bus_write(input logic [daq_pkg::ADDR_W-1:0] addr, input logic [15:0] data);
        @(posedge AD_CLK_40M);
        mcu_cs_n  <= 1'b0;
        mcu_we_n  <= 1'b0;
        mcu_addr  <= addr;
        mcu_wdata <= data;
        @(posedge AD_CLK_40M);
        mcu_cs_n  <= 1'b1;
        mcu_we_n  <= 1'b1;
    endtask

    task automatic bus_read(input logic [daq_pkg::ADDR_W-1:0] addr, output logic [15:0] data);
        @(posedge AD_CLK_40M);
        mcu_cs_n <= 1'b0;
        mcu_rd_n <= 1'b0;
        mcu_addr <= addr;
        @(negedge AD_CLK_40M);                        // mid-cycle, data settled
        check_value("bus output enable", 1, mcu_oe);
        data = mcu_rdata;
        @(posedge AD_CLK_40M);
        mcu_cs_n <= 1'b1;                             // rd_n rise pops a channel
        mcu_rd_n <= 1'b1;
    endtask

    task automatic wait_reg_bit(input logic [daq_pkg::ADDR_W-1:0] addr, input int bit_idx,
                                input string what);
        logic [15:0] value;
        int          polls;
        polls = 0;
        bus_read(addr, value);
        while (!value[bit_idx] && polls < POLL_LIMIT) begin
            polls++;
            bus_read(addr, value);
        end
        if (!value[bit_idx]) stop_run($sformatf("Timeout waiting for %s", what));
    endtask

    task automatic wait_adc_idle();
        int cycles;
        cycles = 0;
        do begin
            @(negedge AD_CLK_40M);
            cycles++;
        end while (u_dut.u_adc.state_q != daq_pkg::IDLE && cycles < 1000);
        if (u_dut.u_adc.state_q != daq_pkg::IDLE) begin
            stop_run("Timeout: the ADC sequencer never went back to idle");
        end
    endtask

    task automatic drive_phase_pulses(input int count, input int period);
        repeat (count) begin
            @(posedge AD_CLK_40M);
            phase <= 1'b1;
            @(posedge AD_CLK_40M);
            phase <= 1'b0;
            repeat (period - 2) @(posedge AD_CLK_40M);
        end
    endtask

    // ------------------------------------------------------------------------
    // test sequence
    // ------------------------------------------------------------------------
    initial begin
        logic [15:0] rd_data;
        logic [15:0] rd_high;
        logic [15:0] wr_data;
        int          next_n [daq_pkg::NUM_CH];        // next sample index per channel
        int          period;
        int          interval;
        int          reads;
        int          cycles;
        int          reset_len;

        void'($urandom(32'h9c6e_3809));
        arst_n    = 1'b0;
        mcu_cs_n  = 1'b1;
        mcu_we_n  = 1'b1;
        mcu_rd_n  = 1'b1;
        mcu_addr  = '0;
        mcu_wdata = '0;
        phase     = 1'b0;
        foreach (next_n[k]) next_n[k] = 0;
        repeat (10) @(posedge AD_CLK_40M);
        arst_n <= 1'b1;

        // idle levels and register readback
        @(negedge AD_CLK_40M);
        check_value("reset convst", 1, adc_convst);
        check_value("reset cs_n", 1, adc_cs_n);
        check_value("reset rd_n", 1, adc_rd_n);
        check_value("reset adc reset", 0, adc_reset);
        bus_read(daq_pkg::ADDR_VERSION, rd_data);
        check_value("version", 16'h1000, rd_data);
        bus_read(daq_pkg::ADDR_STATUS, rd_data);
        check_value("status after reset", 0, rd_data);
        wr_data = 16'($urandom());
        bus_write(daq_pkg::ADDR_INTERVAL, wr_data);
        bus_read(daq_pkg::ADDR_INTERVAL, rd_data);
        check_value("interval readback", wr_data, rd_data);
        wr_data = 16'($urandom());
        bus_write(daq_pkg::ADDR_ENABLE, wr_data);
        bus_read(daq_pkg::ADDR_ENABLE, rd_data);
        check_value("enable readback", {15'b0, wr_data[0]}, rd_data);
        bus_write(daq_pkg::ADDR_ENABLE, 16'h0);

        // phase period and lost phase
        period = $urandom_range(50, 500);
        drive_phase_pulses(3, period);
        bus_read(daq_pkg::ADDR_PERIOD_L, rd_data);
        bus_read(daq_pkg::ADDR_PERIOD_H, rd_high);
        check_value("phase period", period, {rd_high, rd_data});
        repeat (PHASE_TIMEOUT_TB + 100) @(posedge AD_CLK_40M);
        bus_read(daq_pkg::ADDR_PERIOD_L, rd_data);
        bus_read(daq_pkg::ADDR_PERIOD_H, rd_high);
        check_value("period after timeout", 0, {rd_high, rd_data});
        bus_read(daq_pkg::ADDR_DATAFULL, rd_data);
        check_value("lost phase flag", 1, rd_data[1]);

        // sample order per channel
        interval = $urandom_range(80, 200);
        bus_write(daq_pkg::ADDR_INTERVAL, 16'(interval));
        bus_write(daq_pkg::ADDR_ENABLE, 16'h1);
        for (int k = 0; k < daq_pkg::NUM_CH; k++) begin
            reads = $urandom_range(1, 6);
            repeat (reads) begin
                wait_reg_bit(daq_pkg::ADDR_STATUS, k, $sformatf("data in channel %0d", k));
                bus_read(ch_addr(k), rd_data);
                check_value($sformatf("sample order ch%0d", k),
                            expected_sample(k, next_n[k]), rd_data);
                next_n[k]++;
            end
        end

        // fill all FIFOs, stop sampling, then drain
        wait_reg_bit(daq_pkg::ADDR_DATAFULL, 0, "all FIFOs full");
        bus_write(daq_pkg::ADDR_ENABLE, 16'h0);
        wait_adc_idle();
        for (int k = 0; k < daq_pkg::NUM_CH; k++) begin
            for (int i = 0; i < FIFO_DEPTH_TB; i++) begin
                bus_read(ch_addr(k), rd_data);
                check_value($sformatf("full FIFO ch%0d", k),
                            expected_sample(k, next_n[k] + i), rd_data);
            end
            bus_read(ch_addr(k), rd_data);
            check_value($sformatf("empty FIFO ch%0d", k), 0, rd_data);
            bus_read(daq_pkg::ADDR_STATUS, rd_data);
            check_value($sformatf("status bit ch%0d", k), 0, rd_data[k]);
        end

        // re-enable with data queued restarts the ADC and the sample count
        bus_write(daq_pkg::ADDR_ENABLE, 16'h1);
        wait_reg_bit(daq_pkg::ADDR_STATUS, 0, "data before re-enable");
        bus_write(daq_pkg::ADDR_ENABLE, 16'h0);
        bus_write(daq_pkg::ADDR_ENABLE, 16'h1);
        cycles = 0;
        while (!adc_reset && cycles < 20) begin
            @(negedge AD_CLK_40M);
            cycles++;
        end
        if (!adc_reset) stop_run("Timeout: the ADC reset pulse never started");
        reset_len = 0;
        while (adc_reset && reset_len < 20) begin
            reset_len++;
            @(negedge AD_CLK_40M);
        end
        check_value("adc reset length", daq_pkg::ADC_RESET_CYCLES, reset_len);
        bus_read(daq_pkg::ADDR_STATUS, rd_data);
        check_value("status after re-enable", 0, rd_data);
        for (int k = 0; k < daq_pkg::NUM_CH; k++) begin
            wait_reg_bit(daq_pkg::ADDR_STATUS, k, $sformatf("data in channel %0d", k));
            bus_read(ch_addr(k), rd_data);
            check_value($sformatf("first sample ch%0d", k), expected_sample(k, 0), rd_data);
        end

        $display("*** PASSED ***");
        $finish;
    end

endmodule

//--- build.f
hdl/daq_pkg.sv
hdl/mcu_regs.sv
hdl/phase_meter.sv
hdl/sample_trigger.sv
hdl/ad7606_ctrl.sv
hdl/sample_fifo.sv
hdl/daq_top.sv
test/adc_model.sv
test/tb_daq_top.sv

//--- Bender.yml
package:
  name: daq_front_end

sources:
  - hdl/daq_pkg.sv
  - hdl/mcu_regs.sv
  - hdl/phase_meter.sv
  - hdl/sample_trigger.sv
  - hdl/ad7606_ctrl.sv
  - hdl/sample_fifo.sv
  - hdl/daq_top.sv
  - target: test
    files:
      - test/adc_model.sv
      - test/tb_daq_top.sv
